// File: src/isaPkg.sv
package isaPkg;

  // Instruction opcode byte
  typedef logic [7:0] opcode_t;

  // Opcode numbering, consecutive from 1
  localparam opcode_t MovRC     = 8'd1;
  localparam opcode_t MovRR     = 8'd2;
  localparam opcode_t MovRdC    = 8'd3;
  localparam opcode_t MovRdR    = 8'd4;
  localparam opcode_t MovRdRo   = 8'd5;
  localparam opcode_t MovdCR    = 8'd6;
  localparam opcode_t MovdRoR   = 8'd7;
  localparam opcode_t PushR     = 8'd8;
  localparam opcode_t PopR      = 8'd9;
  localparam opcode_t CallR     = 8'd10;
  localparam opcode_t Ret       = 8'd11;
  localparam opcode_t CmpRR     = 8'd12;
  localparam opcode_t CmpRC     = 8'd13;
  localparam opcode_t JmpC      = 8'd14;
  localparam opcode_t JeC       = 8'd15;
  localparam opcode_t JneC      = 8'd16;
  localparam opcode_t AddRRC    = 8'd17;
  localparam opcode_t AddRRR    = 8'd18;
  localparam opcode_t IncR      = 8'd19;
  localparam opcode_t DecR      = 8'd20;
  localparam opcode_t MulAddRRC = 8'd21;
  localparam opcode_t DoutR     = 8'd22;
  localparam opcode_t Stall     = 8'd23;

  // Bit positions inside the first instruction word
  localparam int OpcodeLo = 0;
  localparam int FieldALo = 8;
  localparam int FieldBLo = 16;
  localparam int FieldCLo = 24;

  // Opcodes followed by a constant word
  function automatic logic isLongOpcode(opcode_t op);
    case (op)
      MovRC, MovRdC, MovRdRo, MovdCR, MovdRoR, CmpRC,
      JmpC, JeC, JneC, AddRRC, MulAddRRC:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

  // Opcodes that touch data memory
  function automatic logic isMemOpcode(opcode_t op);
    case (op)
      MovRdC, MovRdR, MovRdRo, MovdCR, MovdRoR, PushR, PopR, CallR, Ret:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

  // Reads among the memory opcodes, stack pops included
  function automatic logic isLoadOpcode(opcode_t op);
    case (op)
      MovRdC, MovRdR, MovRdRo, PopR, Ret:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

  function automatic logic isKnownOpcode(opcode_t op);
    return (op >= MovRC) && (op <= Stall);
  endfunction

endpackage

// File: src/corePkg.sv
package corePkg;

  import isaPkg::*;

  // Data and address word
  typedef logic [31:0] word_t;

  // Direct register index, 64 registers
  typedef logic [5:0] regIndex_t;

  // Registers with a fixed role
  localparam regIndex_t StackReg = 6'd0;
  localparam regIndex_t FlagReg  = 6'd1;
  localparam int        RegCount = 64;

  // Pointer steps
  localparam word_t InstrBytes     = 32'd4;
  localparam word_t LongInstrBytes = 32'd8;
  localparam word_t StackStep      = 32'd4;

  // Instruction phases, one instruction in flight
  typedef enum logic [2:0] {
    Fetch,
    FetchWait,
    Decode,
    ConstWait,
    MemIssue,
    MemWait,
    Writeback
  } phase_t;

  // Latched instruction word
  typedef struct packed {
    opcode_t   opcode;
    regIndex_t a;
    regIndex_t b;
    regIndex_t c;
  } decoded_t;

  // Register values read at Decode
  typedef struct packed {
    word_t a;
    word_t b;
    word_t c;
  } operands_t;

  // Writeback lanes, primary plus stack pointer
  typedef struct packed {
    logic      en;
    regIndex_t idx;
    word_t     data;
    logic      spEn;
    word_t     spData;
  } regWrite_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } ipRedirect_t;

endpackage

// File: src/phaseSequencer.sv
`timescale 1ns/1ps

module phaseSequencer
  import isaPkg::*, corePkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     readAck,
  input  logic     writeAck,
  input  decoded_t instr,
  output phase_t   phase
);

  phase_t nextPhase;
  logic   memAck;

  // Loads finish on a read ack, stores on a write ack
  assign memAck = isLoadOpcode(instr.opcode) ? readAck : writeAck;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      phase <= Fetch;
    end
    else
    begin
      phase <= nextPhase;
    end
  end

  always_comb
  begin
    nextPhase = phase;
    case (phase)
      Fetch:
        nextPhase = FetchWait;
      FetchWait:
        if (readAck)
        begin
          nextPhase = Decode;
        end
      // Branch on the freshly latched opcode
      Decode:
        if (isLongOpcode(instr.opcode))
        begin
          nextPhase = ConstWait;
        end
        else if (isMemOpcode(instr.opcode))
        begin
          nextPhase = MemIssue;
        end
        else
        begin
          nextPhase = Writeback;
        end
      ConstWait:
        if (readAck)
        begin
          nextPhase = isMemOpcode(instr.opcode) ? MemIssue : Writeback;
        end
      MemIssue:
        nextPhase = MemWait;
      MemWait:
        if (memAck)
        begin
          nextPhase = Writeback;
        end
      Writeback:
        nextPhase = Fetch;
      default:
        nextPhase = Fetch;
    endcase
  end

  // Every instruction ends by fetching the next one
  assert property (@(posedge clk) disable iff (reset)
    phase == Writeback |=> phase == Fetch);

  // Data phase only for opcodes that touch memory
  assert property (@(posedge clk) disable iff (reset)
    phase == MemIssue |-> isMemOpcode(instr.opcode));

  // RAM answers only while a request is outstanding
  assert property (@(posedge clk) disable iff (reset)
    (readAck || writeAck) |-> phase inside {FetchWait, ConstWait, MemWait});

endmodule

// File: src/instructionPointer.sv
`timescale 1ns/1ps

module instructionPointer
  import isaPkg::*, corePkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  phase_t      phase,
  input  decoded_t    instr,
  input  ipRedirect_t redirect,
  output word_t       ip
);

  word_t step;

  // Long opcodes carry a trailing constant word
  assign step = isLongOpcode(instr.opcode) ? LongInstrBytes : InstrBytes;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ip <= '0;
    end
    else if (phase == Writeback)
    begin
      if (redirect.taken)
      begin
        ip <= redirect.target;
      end
      // Stall refetches itself, acting as a halt
      else if (instr.opcode != Stall)
      begin
        ip <= ip + step;
      end
    end
  end

endmodule

// File: src/registerFile.sv
`timescale 1ns/1ps

module registerFile
  import corePkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  phase_t    phase,
  input  decoded_t  instr,
  input  regWrite_t wr,
  output operands_t operands,
  output word_t     stackPtr,
  output logic      eqFlag
);

  // r0 lives in stackPtr, the array holds r1 upward
  word_t regs [1:RegCount-1];

  function automatic word_t readReg(regIndex_t idx);
    if (idx == StackReg)
    begin
      return stackPtr;
    end
    return regs[idx];
  endfunction

  // Operand latch at Decode
  always_ff @(posedge clk)
  begin
    if (phase == Decode)
    begin
      operands.a <= readReg(instr.a);
      operands.b <= readReg(instr.b);
      operands.c <= readReg(instr.c);
      // Equal flag for conditional jumps
      eqFlag     <= regs[FlagReg][0];
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr.en && wr.idx != StackReg)
    begin
      regs[wr.idx] <= wr.data;
    end
  end

  // Stack lane wins over a primary write to r0
  // Stack lane data is a signed step added to r0
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      stackPtr <= '0;
    end
    else if (wr.spEn)
    begin
      stackPtr <= stackPtr + wr.spData;
    end
    else if (wr.en && wr.idx == StackReg)
    begin
      stackPtr <= wr.data;
    end
  end

  // Execute unit may only write in Writeback
  assert property (@(posedge clk) disable iff (reset)
    (wr.en || wr.spEn) |-> phase == Writeback);

endmodule

// File: src/memoryPort.sv
`timescale 1ns/1ps

module memoryPort
  import isaPkg::*, corePkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  phase_t    phase,
  input  word_t     ip,
  input  operands_t operands,
  input  word_t     stackPtr,
  input  word_t     ramIn,
  input  logic      readAck,
  output word_t     ramAddress,
  output word_t     ramOut,
  output logic      readReq,
  output logic      writeReq,
  output decoded_t  instr,
  output word_t     constWord,
  output word_t     loadWord
);

  word_t dataAddress;
  word_t dataOut;

  // Data access address and store value per opcode
  always_comb
  begin
    dataAddress = constWord;
    dataOut     = operands.b;
    case (instr.opcode)
      MovRdR:
        dataAddress = operands.b;
      MovRdRo:
        dataAddress = constWord + operands.b;
      PopR, Ret:
        dataAddress = stackPtr - StackStep;
      MovdRoR:
        dataAddress = constWord + operands.a;
      PushR:
      begin
        dataAddress = stackPtr;
        dataOut     = operands.a;
      end
      // Return address is the call's own address
      CallR:
      begin
        dataAddress = stackPtr;
        dataOut     = ip;
      end
      default:
        dataAddress = constWord;
    endcase
  end

  // Request strobes, one cycle each
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      readReq  <= 1'b0;
      writeReq <= 1'b0;
    end
    else
    begin
      readReq  <= (phase == Fetch) ||
                  (phase == Decode && isLongOpcode(instr.opcode)) ||
                  (phase == MemIssue && isLoadOpcode(instr.opcode));
      writeReq <= phase == MemIssue && !isLoadOpcode(instr.opcode);
    end
  end

  // Address and data held until the next request
  always_ff @(posedge clk)
  begin
    case (phase)
      Fetch:
        ramAddress <= ip;
      Decode:
        if (isLongOpcode(instr.opcode))
        begin
          ramAddress <= ip + InstrBytes;
        end
      MemIssue:
      begin
        ramAddress <= dataAddress;
        ramOut     <= dataOut;
      end
      default:
        ramAddress <= ramAddress;
    endcase
  end

  // Instruction word split into opcode and low six bits per field
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      instr <= '0;
    end
    else if (readAck && phase == FetchWait)
    begin
      instr.opcode <= ramIn[OpcodeLo +: $bits(opcode_t)];
      instr.a      <= ramIn[FieldALo +: $bits(regIndex_t)];
      instr.b      <= ramIn[FieldBLo +: $bits(regIndex_t)];
      instr.c      <= ramIn[FieldCLo +: $bits(regIndex_t)];
    end
  end

  // Constant and loaded words
  always_ff @(posedge clk)
  begin
    if (readAck && phase == ConstWait)
    begin
      constWord <= ramIn;
    end
    if (readAck && phase == MemWait)
    begin
      loadWord <= ramIn;
    end
  end

endmodule

// File: src/executeUnit.sv
`timescale 1ns/1ps

module executeUnit
  import isaPkg::*, corePkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  phase_t      phase,
  input  decoded_t    instr,
  input  operands_t   operands,
  input  word_t       constWord,
  input  word_t       loadWord,
  input  logic        eqFlag,
  input  word_t       ip,
  output regWrite_t   wr,
  output ipRedirect_t redirect,
  output logic        debugValid,
  output word_t       debugValue
);

  word_t cmpRhs;
  word_t cmpFlags;
  logic  doutNow;

  // Compare against register B or the constant
  assign cmpRhs   = (instr.opcode == CmpRC) ? constWord : operands.b;
  assign cmpFlags = {29'd0, operands.a > cmpRhs, operands.a < cmpRhs, operands.a == cmpRhs};
  assign doutNow  = (phase == Writeback) && (instr.opcode == DoutR);

  always_comb
  begin
    wr       = '{en: 1'b0, idx: instr.a, data: '0, spEn: 1'b0, spData: '0};
    redirect = '{taken: 1'b0, target: constWord};
    if (phase == Writeback)
    begin
      case (instr.opcode)
        MovRC:
          wr = '{en: 1'b1, idx: instr.a, data: constWord, spEn: 1'b0, spData: '0};
        MovRR:
          wr = '{en: 1'b1, idx: instr.a, data: operands.b, spEn: 1'b0, spData: '0};
        MovRdC, MovRdR, MovRdRo:
          wr = '{en: 1'b1, idx: instr.a, data: loadWord, spEn: 1'b0, spData: '0};
        AddRRC:
          wr.data = operands.b + constWord;
        AddRRR:
          wr.data = operands.b + operands.c;
        IncR:
          wr.data = operands.a + 32'd1;
        DecR:
          wr.data = operands.a - 32'd1;
        MulAddRRC:
          wr.data = operands.a + operands.b * constWord;
        // Flags replace the whole of r1
        CmpRR, CmpRC:
        begin
          wr.idx  = FlagReg;
          wr.data = cmpFlags;
        end
        PopR:
          wr = '{en: 1'b1, idx: instr.a, data: loadWord, spEn: 1'b0, spData: '0};
        default:
          wr.data = '0;
      endcase

      // Arithmetic and compare results use the primary lane
      if (instr.opcode inside {AddRRC, AddRRR, IncR, DecR, MulAddRRC, CmpRR, CmpRC})
      begin
        wr.en = 1'b1;
      end

      // Stack pointer moves by one slot, sent as a signed step
      if (instr.opcode inside {PushR, CallR})
      begin
        wr.spEn   = 1'b1;
        wr.spData = StackStep;
      end
      if (instr.opcode inside {PopR, Ret})
      begin
        wr.spEn   = 1'b1;
        wr.spData = -StackStep;
      end

      // Jumps, call and return
      case (instr.opcode)
        JmpC:
          redirect.taken = 1'b1;
        JeC:
          redirect.taken = eqFlag;
        JneC:
          redirect.taken = !eqFlag;
        CallR:
          redirect = '{taken: 1'b1, target: operands.a};
        Ret:
          redirect = '{taken: 1'b1, target: loadWord + InstrBytes};
        default:
          redirect.taken = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      debugValid <= 1'b0;
    end
    else
    begin
      debugValid <= doutNow;
    end
  end

  // Value shown with the strobe
  always_ff @(posedge clk)
  begin
    if (doutNow)
    begin
      debugValue <= operands.a;
    end
  end

  // Unknown opcodes fall through as a no-op
  assert property (@(posedge clk) disable iff (reset)
    phase == Writeback |-> isKnownOpcode(instr.opcode))
    else $error("Unknown opcode %h at %h", instr.opcode, ip);

endmodule

// File: src/phaethonCore.sv
`timescale 1ns/1ps

module phaethonCore
  import corePkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  word_t ramIn,
  input  logic  readAck,
  input  logic  writeAck,
  output word_t ramAddress,
  output word_t ramOut,
  output logic  readReq,
  output logic  writeReq,
  output logic  debugValid,
  output word_t debugValue
);

  phase_t      phase;
  decoded_t    instr;
  operands_t   operands;
  regWrite_t   wr;
  ipRedirect_t redirect;
  word_t       ip;
  word_t       stackPtr;
  word_t       constWord;
  word_t       loadWord;
  logic        eqFlag;

  // Phase FSM
  phaseSequencer sequencer (
    .clk      (clk),
    .reset    (reset),
    .readAck  (readAck),
    .writeAck (writeAck),
    .instr    (instr),
    .phase    (phase)
  );

  instructionPointer pointer (
    .clk      (clk),
    .reset    (reset),
    .phase    (phase),
    .instr    (instr),
    .redirect (redirect),
    .ip       (ip)
  );

  registerFile regFile (
    .clk      (clk),
    .reset    (reset),
    .phase    (phase),
    .instr    (instr),
    .wr       (wr),
    .operands (operands),
    .stackPtr (stackPtr),
    .eqFlag   (eqFlag)
  );

  // RAM side, also holds the instruction latch
  memoryPort memPort (
    .clk        (clk),
    .reset      (reset),
    .phase      (phase),
    .ip         (ip),
    .operands   (operands),
    .stackPtr   (stackPtr),
    .ramIn      (ramIn),
    .readAck    (readAck),
    .ramAddress (ramAddress),
    .ramOut     (ramOut),
    .readReq    (readReq),
    .writeReq   (writeReq),
    .instr      (instr),
    .constWord  (constWord),
    .loadWord   (loadWord)
  );

  executeUnit execUnit (
    .clk        (clk),
    .reset      (reset),
    .phase      (phase),
    .instr      (instr),
    .operands   (operands),
    .constWord  (constWord),
    .loadWord   (loadWord),
    .eqFlag     (eqFlag),
    .ip         (ip),
    .wr         (wr),
    .redirect   (redirect),
    .debugValid (debugValid),
    .debugValue (debugValue)
  );

endmodule

// File: dv/ramModel.sv
`timescale 1ns/1ps

module ramModel
  import corePkg::*;
#(
  parameter int MemWords = 1024
)
(
  input  logic  clk,
  input  logic  randomDelay,
  input  logic  readReq,
  input  logic  writeReq,
  input  word_t ramAddress,
  input  word_t ramOut,
  output logic  readAck,
  output logic  writeAck,
  output word_t ramIn
);

  // One logged store
  typedef struct packed {
    word_t addr;
    word_t data;
  } ramWrite_t;

  localparam int IndexBits = $clog2(MemWords);

  // Word-addressed storage, byte address bits 1:0 ignored
  word_t     mem [0:MemWords-1];
  ramWrite_t writeLog [$];

  int    delay;
  word_t reqAddr;
  word_t reqData;
  logic  reqWrite;

  initial
  begin
    readAck  = 1'b0;
    writeAck = 1'b0;
    ramIn    = '0;
  end

  // Requests sampled on the falling edge where they are stable
  initial
  begin
    // Fixed seed for the delay draws
    void'($urandom(32'h3958_811a));
    forever
    begin
      @(negedge clk);
      if (readReq || writeReq)
      begin
        reqAddr  = ramAddress;
        reqData  = ramOut;
        reqWrite = writeReq;
        delay    = randomDelay ? $urandom_range(5, 1) : 1;
        repeat (delay) @(negedge clk);
        if (reqWrite)
        begin
          mem[reqAddr[IndexBits+1:2]] = reqData;
          writeLog.push_back('{addr: reqAddr, data: reqData});
          writeAck = 1'b1;
        end
        else
        begin
          ramIn   = mem[reqAddr[IndexBits+1:2]];
          readAck = 1'b1;
        end
        // Acknowledge lasts one cycle
        @(negedge clk);
        readAck  = 1'b0;
        writeAck = 1'b0;
      end
    end
  end

endmodule

// File: dv/coreTb.sv
`timescale 1ns/1ps

module coreTb
  import isaPkg::*, corePkg::*;
();

  localparam time ClkPeriod      = 100ns;
  localparam int  MaxDelay       = 5;
  localparam int  Runs           = 6;
  localparam int  InstrPerRun    = 40;
  // Fetch, constant and data waits at worst plus fixed phases
  localparam int  CyclesPerInstr = 4 + 3 * (MaxDelay + 1);
  localparam int  RunLimit       = 2 * InstrPerRun * CyclesPerInstr;
  localparam int  WatchdogCycles = 2 * Runs * (InstrPerRun * CyclesPerInstr + 20);

  logic  clk;
  logic  reset;
  logic  randomDelay;
  word_t ramIn;
  logic  readAck;
  logic  writeAck;
  word_t ramAddress;
  word_t ramOut;
  logic  readReq;
  logic  writeReq;
  logic  debugValid;
  word_t debugValue;

  int    errors;
  int    checks;
  int    haltFetches;
  word_t haltAddr;
  word_t prog [$];
  word_t debugQ [$];
  word_t expDebug [$];

  // Reference runs kept for the back-pressure rerun
  word_t arithDebug [$];
  word_t stackDebug [$];
  word_t stackLogAddr [$];
  word_t stackLogData [$];

  phaethonCore DUT (
    .clk        (clk),
    .reset      (reset),
    .ramIn      (ramIn),
    .readAck    (readAck),
    .writeAck   (writeAck),
    .ramAddress (ramAddress),
    .ramOut     (ramOut),
    .readReq    (readReq),
    .writeReq   (writeReq),
    .debugValid (debugValid),
    .debugValue (debugValue)
  );

  ramModel ram (
    .clk         (clk),
    .randomDelay (randomDelay),
    .readReq     (readReq),
    .writeReq    (writeReq),
    .ramAddress  (ramAddress),
    .ramOut      (ramOut),
    .readAck     (readAck),
    .writeAck    (writeAck),
    .ramIn       (ramIn)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // Debug strobes and refetches of the final Stall
  always @(negedge clk)
  begin
    if (!reset && debugValid)
    begin
      debugQ.push_back(debugValue);
    end
    if (!reset && readReq && ramAddress == haltAddr)
    begin
      haltFetches++;
    end
  end

  task automatic checkValue(string name, word_t actual, word_t expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  function automatic word_t encode(opcode_t op, regIndex_t a, regIndex_t b, regIndex_t c);
    return {2'b00, c, 2'b00, b, 2'b00, a, op};
  endfunction

  task automatic emit(opcode_t op, regIndex_t a, regIndex_t b, regIndex_t c);
    prog.push_back(encode(op, a, b, c));
  endtask

  task automatic emitLong(opcode_t op, regIndex_t a, regIndex_t b, word_t value);
    prog.push_back(encode(op, a, b, 6'd0));
    prog.push_back(value);
  endtask

  function automatic word_t here();
    return prog.size() * 4;
  endfunction

  // Load prog, reset the core and run until the Stall at stopAt repeats
  task automatic runProgram(word_t stopAt);
    int cycles;
    @(negedge clk);
    reset = 1'b1;
    for (int i = 0; i < 1024; i++)
    begin
      ram.mem[i] = '0;
    end
    foreach (prog[i])
    begin
      ram.mem[i] = prog[i];
    end
    haltAddr = stopAt;
    repeat (10) @(negedge clk);
    ram.writeLog.delete();
    debugQ.delete();
    haltFetches = 0;
    reset = 1'b0;
    cycles = 0;
    while (haltFetches < 2 && cycles < RunLimit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (haltFetches < 2)
    begin
      errors++;
      $display("Program did not reach its final Stall within %0d cycles", RunLimit);
    end
  endtask

  task automatic checkDebug();
    checkValue("debugCount", debugQ.size(), expDebug.size());
    foreach (expDebug[i])
    begin
      if (i < debugQ.size())
      begin
        checkValue($sformatf("debugValue[%0d]", i), debugQ[i], expDebug[i]);
      end
    end
  endtask

  task automatic testArith();
    word_t v2;
    word_t stop;
    v2 = 32'h1234_5678;
    prog.delete();
    emitLong(MovRC, 2, 0, v2);
    emit(MovRR, 3, 2, 0);
    emitLong(AddRRC, 4, 3, 32'h1111_1111);
    emit(AddRRR, 5, 4, 2);
    emit(IncR, 5, 0, 0);
    emit(DecR, 3, 0, 0);
    emitLong(MovRC, 6, 0, 32'd7);
    emitLong(MulAddRRC, 6, 2, 32'd9);
    for (int r = 2; r <= 6; r++)
    begin
      emit(DoutR, r, 0, 0);
    end
    stop = here();
    emit(Stall, 0, 0, 0);
    runProgram(stop);
    expDebug = '{v2, v2 - 32'd1, v2 + 32'h1111_1111,
                 v2 + 32'h1111_1111 + v2 + 32'd1, 32'd7 + v2 * 32'd9};
    checkDebug();
  endtask

  task automatic testMemory();
    word_t stop;
    prog.delete();
    emitLong(MovRC, 2, 0, 32'hCAFE_0001);
    emitLong(MovRC, 3, 0, 32'h40);
    emitLong(MovRC, 4, 0, 32'hBEEF_0002);
    emitLong(MovRC, 7, 0, 32'h240);
    emitLong(MovdCR, 0, 2, 32'h200);
    emitLong(MovdRoR, 3, 4, 32'h200);
    emitLong(MovRdC, 5, 0, 32'h200);
    emit(MovRdR, 6, 7, 0);
    emitLong(MovRdRo, 8, 3, 32'h200);
    emit(DoutR, 5, 0, 0);
    emit(DoutR, 6, 0, 0);
    emit(DoutR, 8, 0, 0);
    stop = here();
    emit(Stall, 0, 0, 0);
    runProgram(stop);
    checkValue("writeCount", ram.writeLog.size(), 2);
    if (ram.writeLog.size() == 2)
    begin
      checkValue("writeAddr[0]", ram.writeLog[0].addr, 32'h200);
      checkValue("writeData[0]", ram.writeLog[0].data, 32'hCAFE_0001);
      checkValue("writeAddr[1]", ram.writeLog[1].addr, 32'h240);
      checkValue("writeData[1]", ram.writeLog[1].data, 32'hBEEF_0002);
    end
    expDebug = '{32'hCAFE_0001, 32'hBEEF_0002, 32'hBEEF_0002};
    checkDebug();
  endtask

  task automatic testStack();
    word_t callAddr;
    word_t stop;
    prog.delete();
    emitLong(MovRC, 0, 0, 32'h800);
    emitLong(MovRC, 2, 0, 32'hAAAA_0003);
    emit(PushR, 2, 0, 0);
    emitLong(MovRC, 3, 0, 32'h100);
    callAddr = here();
    emit(CallR, 3, 0, 0);
    emit(PopR, 4, 0, 0);
    emit(DoutR, 4, 0, 0);
    emit(DoutR, 0, 0, 0);
    stop = here();
    emit(Stall, 0, 0, 0);
    // Subroutine at 0x100
    while (prog.size() < 'h40)
    begin
      prog.push_back('0);
    end
    emitLong(MovRC, 5, 0, 32'h55);
    emit(DoutR, 5, 0, 0);
    emit(Ret, 0, 0, 0);
    runProgram(stop);
    checkValue("writeCount", ram.writeLog.size(), 2);
    if (ram.writeLog.size() == 2)
    begin
      checkValue("pushAddr", ram.writeLog[0].addr, 32'h800);
      checkValue("pushData", ram.writeLog[0].data, 32'hAAAA_0003);
      checkValue("callAddr", ram.writeLog[1].addr, 32'h804);
      checkValue("callData", ram.writeLog[1].data, callAddr);
    end
    expDebug = '{32'h55, 32'hAAAA_0003, 32'h800};
    checkDebug();
  endtask

  task automatic testBranch();
    int    jmpIdx [5];
    word_t stop;
    prog.delete();
    emitLong(MovRC, 2, 0, 32'd5);
    emitLong(MovRC, 3, 0, 32'd5);
    emitLong(MovRC, 6, 0, 32'h11);
    emitLong(MovRC, 7, 0, 32'h22);
    emitLong(MovRC, 8, 0, 32'h33);
    emit(CmpRR, 2, 3, 0);
    emit(DoutR, FlagReg, 0, 0);
    // Below only when compared unsigned
    emitLong(CmpRC, 2, 0, 32'hFFFF_FFF9);
    emit(DoutR, FlagReg, 0, 0);
    emitLong(CmpRC, 2, 0, 32'd3);
    emit(DoutR, FlagReg, 0, 0);
    // Equal flag clear: JeC falls through, JneC jumps
    jmpIdx[0] = prog.size();
    emitLong(JeC, 0, 0, 0);
    emit(DoutR, 6, 0, 0);
    prog[jmpIdx[0] + 1] = here();
    jmpIdx[1] = prog.size();
    emitLong(JneC, 0, 0, 0);
    emit(DoutR, 7, 0, 0);
    prog[jmpIdx[1] + 1] = here();
    // Equal flag set: JeC jumps, JneC falls through
    emit(CmpRR, 2, 3, 0);
    jmpIdx[2] = prog.size();
    emitLong(JeC, 0, 0, 0);
    emit(DoutR, 7, 0, 0);
    prog[jmpIdx[2] + 1] = here();
    jmpIdx[3] = prog.size();
    emitLong(JneC, 0, 0, 0);
    emit(DoutR, 8, 0, 0);
    prog[jmpIdx[3] + 1] = here();
    jmpIdx[4] = prog.size();
    emitLong(JmpC, 0, 0, 0);
    emit(DoutR, 7, 0, 0);
    prog[jmpIdx[4] + 1] = here();
    stop = here();
    emit(Stall, 0, 0, 0);
    runProgram(stop);
    // Flag word: equal in bit 0, below in bit 1, above in bit 2
    expDebug = '{32'h1, 32'h2, 32'h4, 32'h11, 32'h33};
    checkDebug();
  endtask

  task automatic compareRuns(string name, word_t saved [$], word_t now [$]);
    checkValue({name, "Count"}, now.size(), saved.size());
    foreach (saved[i])
    begin
      if (i < now.size())
      begin
        checkValue($sformatf("%s[%0d]", name, i), now[i], saved[i]);
      end
    end
  endtask

  task automatic testBackPressure();
    word_t logAddr [$];
    word_t logData [$];
    randomDelay = 1'b1;
    testArith();
    compareRuns("arithDebug", arithDebug, debugQ);
    testStack();
    foreach (ram.writeLog[i])
    begin
      logAddr.push_back(ram.writeLog[i].addr);
      logData.push_back(ram.writeLog[i].data);
    end
    compareRuns("stackDebug", stackDebug, debugQ);
    compareRuns("stackLogAddr", stackLogAddr, logAddr);
    compareRuns("stackLogData", stackLogData, logData);
    randomDelay = 1'b0;
  endtask

  // Run limit from the worst case of all programs
  initial
  begin
    #(WatchdogCycles * ClkPeriod);
    $display("Run timed out after %0d cycles", WatchdogCycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial
  begin
    clk         = 1'b0;
    reset       = 1'b1;
    randomDelay = 1'b0;
    errors      = 0;
    checks      = 0;
    haltFetches = 0;
    haltAddr    = '1;
    testArith();
    arithDebug = debugQ;
    testMemory();
    testStack();
    stackDebug = debugQ;
    foreach (ram.writeLog[i])
    begin
      stackLogAddr.push_back(ram.writeLog[i].addr);
      stackLogData.push_back(ram.writeLog[i].data);
    end
    testBranch();
    testBackPressure();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: sim.f
src/isaPkg.sv
src/corePkg.sv
src/phaseSequencer.sv
src/instructionPointer.sv
src/registerFile.sv
src/memoryPort.sv
src/executeUnit.sv
src/phaethonCore.sv
dv/ramModel.sv
dv/coreTb.sv

// File: run.sh
#!/bin/bash
# Compile with Verilator and run; status follows the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module coreTb -o coreSim || exit 1
out="$(./obj_dir/coreSim)"
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1
